// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_vcache_array
FLIST     ?= list.f
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR)

// ==== list.f ====
+incdir+logic
logic/vcache_pkg.sv
logic/mem_link_pkg.sv
logic/vcache_req_in.sv
logic/vcache_core.sv
logic/vcache_rsp_out.sv
logic/ruche_buffer.sv
logic/vcache_tile.sv
logic/vcache_array.sv
verif/tb_vcache_array.sv

// ==== logic/mem_link_pkg.sv ====
`include "vcache_cfg.svh"

package mem_link_pkg;

  typedef logic [`VC_ADDR_W-1:0] addr_t;
  typedef logic [`VC_DATA_W-1:0] data_t;

  // address split for a direct-mapped cache
  typedef logic [`VC_SETS_LOG2-1:0] index_t;
  typedef logic [`VC_ADDR_W-`VC_SETS_LOG2-1:0] tag_t;

endpackage

// ==== logic/ruche_buffer.sv ====
`timescale 1ns/1ps

module ruche_buffer (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                fwd_v_i,
  input  logic                fwd_write_i,
  input  mem_link_pkg::addr_t fwd_addr_i,
  input  mem_link_pkg::data_t fwd_data_i,
  output logic                fwd_ready_o,
  output logic                fwd_v_o,
  output logic                fwd_write_o,
  output mem_link_pkg::addr_t fwd_addr_o,
  output mem_link_pkg::data_t fwd_data_o,
  input  logic                fwd_ready_i,
  input  logic                rev_v_i,
  input  mem_link_pkg::data_t rev_data_i,
  output logic                rev_v_o,
  output mem_link_pkg::data_t rev_data_o
);
  import mem_link_pkg::*;

  logic  full_q;
  logic  write_q;
  addr_t addr_q;
  data_t data_q;
  logic  rev_v_q;
  data_t rev_data_q;

  // single slot, only fills when empty
  assign fwd_ready_o = !full_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
      rev_v_q <= 1'b0;
    end else begin
      if (fwd_v_i && !full_q) begin
        full_q <= 1'b1;
      end else if (fwd_ready_i) begin
        full_q <= 1'b0;
      end
      rev_v_q <= rev_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fwd_v_i && !full_q) begin
      write_q <= fwd_write_i;
      addr_q <= fwd_addr_i;
      data_q <= fwd_data_i;
    end
    if (rev_v_i) begin
      rev_data_q <= rev_data_i;
    end
  end

  assign fwd_v_o = full_q;
  assign fwd_write_o = write_q;
  assign fwd_addr_o = addr_q;
  assign fwd_data_o = data_q;
  assign rev_v_o = rev_v_q;
  assign rev_data_o = rev_data_q;

endmodule

// ==== logic/vcache_array.sv ====
`timescale 1ns/1ps

`include "vcache_cfg.svh"

module vcache_array (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  input  logic [`VC_NUM_TILES-1:0]                      req_v_i,
  input  vcache_pkg::vc_op_e [`VC_NUM_TILES-1:0]        req_op_i,
  input  mem_link_pkg::addr_t [`VC_NUM_TILES-1:0]       req_addr_i,
  input  mem_link_pkg::data_t [`VC_NUM_TILES-1:0]       req_data_i,
  output logic [`VC_NUM_TILES-1:0]                      req_ready_o,
  output logic [`VC_NUM_TILES-1:0]                      rsp_v_o,
  output vcache_pkg::vc_op_e [`VC_NUM_TILES-1:0]        rsp_op_o,
  output mem_link_pkg::data_t [`VC_NUM_TILES-1:0]       rsp_data_o,
  input  logic [`VC_NUM_TILES-1:0]                      rsp_ready_i,
  output logic [`VC_NUM_TILES-1:0]                      mem_v_o,
  output logic [`VC_NUM_TILES-1:0]                      mem_write_o,
  output mem_link_pkg::addr_t [`VC_NUM_TILES-1:0]       mem_addr_o,
  output mem_link_pkg::data_t [`VC_NUM_TILES-1:0]       mem_data_o,
  input  logic [`VC_NUM_TILES-1:0]                      mem_ready_i,
  input  logic [`VC_NUM_TILES-1:0]                      mem_rdata_v_i,
  input  mem_link_pkg::data_t [`VC_NUM_TILES-1:0]       mem_rdata_i
);

  // each tile owns its own memory channel
  for (genvar t = 0; t < `VC_NUM_TILES; t++) begin : tile
    vcache_tile vc (
      .clk_i(clk_i), .rst_i(rst_i),
      .req_v_i(req_v_i[t]), .req_op_i(req_op_i[t]),
      .req_addr_i(req_addr_i[t]), .req_data_i(req_data_i[t]),
      .req_ready_o(req_ready_o[t]),
      .rsp_v_o(rsp_v_o[t]), .rsp_op_o(rsp_op_o[t]), .rsp_data_o(rsp_data_o[t]),
      .rsp_ready_i(rsp_ready_i[t]),
      .mem_v_o(mem_v_o[t]), .mem_write_o(mem_write_o[t]),
      .mem_addr_o(mem_addr_o[t]), .mem_data_o(mem_data_o[t]),
      .mem_ready_i(mem_ready_i[t]),
      .mem_rdata_v_i(mem_rdata_v_i[t]), .mem_rdata_i(mem_rdata_i[t])
    );
  end

endmodule

// ==== logic/vcache_cfg.svh ====
`ifndef VCACHE_CFG_SVH
`define VCACHE_CFG_SVH

// tiles in the row
`define VC_NUM_TILES 2

// word address and data widths
`define VC_ADDR_W 10
`define VC_DATA_W 32

// log2 of cache lines per tile
`define VC_SETS_LOG2 3

// registered stages on each memory channel
`define VC_RUCHE_STAGES 2

`endif

// ==== logic/vcache_core.sv ====
`timescale 1ns/1ps

`include "vcache_cfg.svh"

module vcache_core (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                core_v_i,
  input  vcache_pkg::vc_op_e  core_op_i,
  input  mem_link_pkg::addr_t core_addr_i,
  input  mem_link_pkg::data_t core_data_i,
  output logic                core_ready_o,
  output logic                rsp_v_o,
  output vcache_pkg::vc_op_e  rsp_op_o,
  output mem_link_pkg::data_t rsp_data_o,
  input  logic                rsp_ready_i,
  output logic                mem_v_o,
  output logic                mem_write_o,
  output mem_link_pkg::addr_t mem_addr_o,
  output mem_link_pkg::data_t mem_data_o,
  input  logic                mem_ready_i,
  input  logic                mem_rdata_v_i,
  input  mem_link_pkg::data_t mem_rdata_i
);
  import vcache_pkg::*;
  import mem_link_pkg::*;

  localparam int LINES = 1 << `VC_SETS_LOG2;

  vc_state_e        state_q;
  logic [LINES-1:0] valid_q;
  tag_t             tag_mem [LINES];
  data_t            data_mem [LINES];

  // request held during a miss or write
  vc_op_e op_q;
  addr_t  addr_q;
  data_t  data_q;

  logic   rsp_v_q;
  vc_op_e rsp_op_q;
  data_t  rsp_data_q;

  index_t idx;
  tag_t   tag;
  index_t idx_q;
  tag_t   tag_q;
  logic   hit;
  logic   take;
  logic   mem_done;
  logic   fill;

  assign {tag, idx} = core_addr_i;
  assign {tag_q, idx_q} = addr_q;

  assign hit = valid_q[idx] && (tag_mem[idx] == tag);

  // only take a new request once the response slot frees up
  assign core_ready_o = (state_q == ST_IDLE) && (!rsp_v_q || rsp_ready_i);
  assign take = core_v_i && core_ready_o;

  // read data or write ack
  assign mem_done = (state_q == ST_FILL_WAIT) && mem_rdata_v_i;
  assign fill = mem_done && (op_q == OP_LOAD);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      valid_q <= '0;
      rsp_v_q <= 1'b0;
    end else begin
      if (rsp_v_q && rsp_ready_i) begin
        rsp_v_q <= 1'b0;
      end
      case (state_q)
        ST_IDLE: begin
          if (take) begin
            if (core_op_i == OP_STORE) begin
              state_q <= ST_WRITE;
            end else if (hit) begin
              rsp_v_q <= 1'b1;
            end else begin
              state_q <= ST_FILL_REQ;
            end
          end
        end
        ST_FILL_REQ, ST_WRITE: begin
          if (mem_ready_i) begin
            state_q <= ST_FILL_WAIT;
          end
        end
        ST_FILL_WAIT: begin
          if (mem_done) begin
            rsp_v_q <= 1'b1;
            state_q <= ST_IDLE;
          end
          if (fill) begin
            valid_q[idx_q] <= 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      op_q <= core_op_i;
      addr_q <= core_addr_i;
      data_q <= core_data_i;
    end
    if (take && (core_op_i == OP_LOAD) && hit) begin
      rsp_op_q <= OP_LOAD;
      rsp_data_q <= data_mem[idx];
    end
    if (mem_done) begin
      rsp_op_q <= op_q;
      rsp_data_q <= (op_q == OP_LOAD) ? mem_rdata_i : data_q;
    end
  end

  // store hit updates in place, load miss replaces the line
  always_ff @(posedge clk_i) begin
    if (take && (core_op_i == OP_STORE) && hit) begin
      data_mem[idx] <= core_data_i;
    end
    if (fill) begin
      tag_mem[idx_q] <= tag_q;
      data_mem[idx_q] <= mem_rdata_i;
    end
  end

  assign mem_v_o = (state_q == ST_FILL_REQ) || (state_q == ST_WRITE);
  assign mem_write_o = (state_q == ST_WRITE);
  assign mem_addr_o = addr_q;
  assign mem_data_o = data_q;

  assign rsp_v_o = rsp_v_q;
  assign rsp_op_o = rsp_op_q;
  assign rsp_data_o = rsp_data_q;

endmodule

// ==== logic/vcache_pkg.sv ====
`include "vcache_cfg.svh"

package vcache_pkg;

  // request and response operation
  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } vc_op_e;

  // miss/write controller
  typedef enum logic [1:0] {
    ST_IDLE      = 2'd0,
    ST_FILL_REQ  = 2'd1,
    // also waits for the write ack
    ST_FILL_WAIT = 2'd2,
    ST_WRITE     = 2'd3
  } vc_state_e;

endpackage

// ==== logic/vcache_req_in.sv ====
`timescale 1ns/1ps

module vcache_req_in (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                req_v_i,
  input  vcache_pkg::vc_op_e  req_op_i,
  input  mem_link_pkg::addr_t req_addr_i,
  input  mem_link_pkg::data_t req_data_i,
  output logic                req_ready_o,
  output logic                core_v_o,
  output vcache_pkg::vc_op_e  core_op_o,
  output mem_link_pkg::addr_t core_addr_o,
  output mem_link_pkg::data_t core_data_o,
  input  logic                core_ready_i
);
  import vcache_pkg::*;
  import mem_link_pkg::*;

  logic   full_q;
  logic   up_q;
  logic   take;
  vc_op_e op_q;
  addr_t  addr_q;
  data_t  data_q;

  // open once out of reset, then when empty or draining
  assign req_ready_o = up_q && (!full_q || core_ready_i);
  assign take = req_v_i && req_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      up_q <= 1'b0;
      full_q <= 1'b0;
    end else begin
      up_q <= 1'b1;
      if (take) begin
        full_q <= 1'b1;
      end else if (core_ready_i) begin
        full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      op_q <= req_op_i;
      addr_q <= req_addr_i;
      data_q <= req_data_i;
    end
  end

  assign core_v_o = full_q;
  assign core_op_o = op_q;
  assign core_addr_o = addr_q;
  assign core_data_o = data_q;

endmodule

// ==== logic/vcache_rsp_out.sv ====
`timescale 1ns/1ps

module vcache_rsp_out (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                in_v_i,
  input  vcache_pkg::vc_op_e  in_op_i,
  input  mem_link_pkg::data_t in_data_i,
  output logic                in_ready_o,
  output logic                rsp_v_o,
  output vcache_pkg::vc_op_e  rsp_op_o,
  output mem_link_pkg::data_t rsp_data_o,
  input  logic                rsp_ready_i
);
  import vcache_pkg::*;
  import mem_link_pkg::*;

  logic   full_q;
  vc_op_e op_q;
  data_t  data_q;

  // refill in the same cycle the north side drains
  assign in_ready_o = !full_q || rsp_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (in_ready_o) begin
      full_q <= in_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_v_i && in_ready_o) begin
      op_q <= in_op_i;
      data_q <= in_data_i;
    end
  end

  assign rsp_v_o = full_q;
  assign rsp_op_o = op_q;
  assign rsp_data_o = data_q;

endmodule

// ==== logic/vcache_tile.sv ====
`timescale 1ns/1ps

`include "vcache_cfg.svh"

module vcache_tile (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                req_v_i,
  input  vcache_pkg::vc_op_e  req_op_i,
  input  mem_link_pkg::addr_t req_addr_i,
  input  mem_link_pkg::data_t req_data_i,
  output logic                req_ready_o,
  output logic                rsp_v_o,
  output vcache_pkg::vc_op_e  rsp_op_o,
  output mem_link_pkg::data_t rsp_data_o,
  input  logic                rsp_ready_i,
  output logic                mem_v_o,
  output logic                mem_write_o,
  output mem_link_pkg::addr_t mem_addr_o,
  output mem_link_pkg::data_t mem_data_o,
  input  logic                mem_ready_i,
  input  logic                mem_rdata_v_i,
  input  mem_link_pkg::data_t mem_rdata_i
);
  import vcache_pkg::*;
  import mem_link_pkg::*;

  localparam int NS = `VC_RUCHE_STAGES;

  logic   core_v;
  logic   core_ready;
  vc_op_e core_op;
  addr_t  core_addr;
  data_t  core_data;

  logic   cr_v;
  logic   cr_ready;
  vc_op_e cr_op;
  data_t  cr_data;

  // index 0 is the core side, NS the outside
  logic [NS:0]  fwd_v;
  logic [NS:0]  fwd_ready;
  logic [NS:0]  fwd_write;
  addr_t [NS:0] fwd_addr;
  data_t [NS:0] fwd_data;
  logic [NS:0]  rev_v;
  data_t [NS:0] rev_data;

  vcache_req_in req_in0 (
    .clk_i(clk_i), .rst_i(rst_i),
    .req_v_i(req_v_i), .req_op_i(req_op_i),
    .req_addr_i(req_addr_i), .req_data_i(req_data_i), .req_ready_o(req_ready_o),
    .core_v_o(core_v), .core_op_o(core_op),
    .core_addr_o(core_addr), .core_data_o(core_data), .core_ready_i(core_ready)
  );

  vcache_core core0 (
    .clk_i(clk_i), .rst_i(rst_i),
    .core_v_i(core_v), .core_op_i(core_op), .core_addr_i(core_addr),
    .core_data_i(core_data), .core_ready_o(core_ready),
    .rsp_v_o(cr_v), .rsp_op_o(cr_op), .rsp_data_o(cr_data), .rsp_ready_i(cr_ready),
    .mem_v_o(fwd_v[0]), .mem_write_o(fwd_write[0]), .mem_addr_o(fwd_addr[0]),
    .mem_data_o(fwd_data[0]), .mem_ready_i(fwd_ready[0]),
    .mem_rdata_v_i(rev_v[0]), .mem_rdata_i(rev_data[0])
  );

  vcache_rsp_out rsp_out0 (
    .clk_i(clk_i), .rst_i(rst_i),
    .in_v_i(cr_v), .in_op_i(cr_op), .in_data_i(cr_data), .in_ready_o(cr_ready),
    .rsp_v_o(rsp_v_o), .rsp_op_o(rsp_op_o), .rsp_data_o(rsp_data_o),
    .rsp_ready_i(rsp_ready_i)
  );

  for (genvar s = 0; s < NS; s++) begin : rb
    ruche_buffer stage (
      .clk_i(clk_i), .rst_i(rst_i),
      .fwd_v_i(fwd_v[s]), .fwd_write_i(fwd_write[s]),
      .fwd_addr_i(fwd_addr[s]), .fwd_data_i(fwd_data[s]), .fwd_ready_o(fwd_ready[s]),
      .fwd_v_o(fwd_v[s+1]), .fwd_write_o(fwd_write[s+1]),
      .fwd_addr_o(fwd_addr[s+1]), .fwd_data_o(fwd_data[s+1]),
      .fwd_ready_i(fwd_ready[s+1]),
      .rev_v_i(rev_v[s+1]), .rev_data_i(rev_data[s+1]),
      .rev_v_o(rev_v[s]), .rev_data_o(rev_data[s])
    );
  end

  assign mem_v_o = fwd_v[NS];
  assign mem_write_o = fwd_write[NS];
  assign mem_addr_o = fwd_addr[NS];
  assign mem_data_o = fwd_data[NS];
  assign fwd_ready[NS] = mem_ready_i;
  assign rev_v[NS] = mem_rdata_v_i;
  assign rev_data[NS] = mem_rdata_i;

endmodule

// ==== verif/tb_vcache_array.sv ====
`timescale 1ns/1ps

`include "vcache_cfg.svh"

module tb_vcache_array;
  import vcache_pkg::*;
  import mem_link_pkg::*;

  localparam int NT = `VC_NUM_TILES;
  localparam int LINES = 1 << `VC_SETS_LOG2;
  localparam int WORDS = 1 << `VC_ADDR_W;
  localparam int REQS = 200;
  // ruche round trip, memory delay and pipeline per request, times 4 for stalls
  localparam int LIMIT = REQS * (2 * `VC_RUCHE_STAGES * 2 + 4 + 6) * 4;

  logic            clk_i;
  logic            rst_i;
  logic [NT-1:0]   req_v_i;
  vc_op_e [NT-1:0] req_op_i;
  addr_t [NT-1:0]  req_addr_i;
  data_t [NT-1:0]  req_data_i;
  logic [NT-1:0]   req_ready_o;
  logic [NT-1:0]   rsp_v_o;
  vc_op_e [NT-1:0] rsp_op_o;
  data_t [NT-1:0]  rsp_data_o;
  logic [NT-1:0]   rsp_ready_i;
  logic [NT-1:0]   mem_v_o;
  logic [NT-1:0]   mem_write_o;
  addr_t [NT-1:0]  mem_addr_o;
  data_t [NT-1:0]  mem_data_o;
  logic [NT-1:0]   mem_ready_i;
  logic [NT-1:0]   mem_rdata_v_i;
  data_t [NT-1:0]  mem_rdata_i;

  int seed = 32'h3e461d41;
  int cycles = 0;
  int low_cycles = 0;
  int issued [NT];
  int received [NT];

  // reference model of memory, cache lines and expected traffic
  data_t            model_mem [NT][WORDS];
  logic [LINES-1:0] line_valid [NT];
  tag_t             line_tag [NT][LINES];
  vc_op_e           exp_op_q [NT][$];
  data_t            exp_data_q [NT][$];
  logic             exp_mw_q [NT][$];
  addr_t            exp_ma_q [NT][$];
  data_t            exp_md_q [NT][$];

  // memory responder
  data_t mem_words [NT][WORDS];
  data_t ret_q [NT][$];
  int    due_q [NT][$];

  vcache_array dut0 (
    .clk_i(clk_i), .rst_i(rst_i),
    .req_v_i(req_v_i), .req_op_i(req_op_i), .req_addr_i(req_addr_i),
    .req_data_i(req_data_i), .req_ready_o(req_ready_o),
    .rsp_v_o(rsp_v_o), .rsp_op_o(rsp_op_o), .rsp_data_o(rsp_data_o),
    .rsp_ready_i(rsp_ready_i),
    .mem_v_o(mem_v_o), .mem_write_o(mem_write_o), .mem_addr_o(mem_addr_o),
    .mem_data_o(mem_data_o), .mem_ready_i(mem_ready_i),
    .mem_rdata_v_i(mem_rdata_v_i), .mem_rdata_i(mem_rdata_i)
  );

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  // odd multiplier keeps every address distinct
  function automatic data_t fill_word(input int t, input int a);
    return data_t'((32'h9e3779b1 * (a + 1)) ^ (t << 24) ^ 32'h5a5a0000);
  endfunction

  // two tags over all indexes, so hits and conflicts both happen
  function automatic addr_t pick_addr();
    logic [31:0] r;
    tag_t        tg;
    index_t      ix;
    r = rand_word();
    tg = r[0] ? tag_t'(43) : tag_t'(5);
    ix = index_t'(r[15:1]);
    return {tg, ix};
  endfunction

  task automatic report_fail();
    $display("Simulation FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_op(input string name, input vc_op_e exp, input vc_op_e act);
    if (act !== exp) begin
      $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
      report_fail();
    end
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      report_fail();
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      report_fail();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
      report_fail();
    end
  endtask

  task automatic check_quiet(input string phase, input logic with_ready);
    for (int t = 0; t < NT; t++) begin
      check_bit($sformatf("%s tile %0d rsp_v", phase, t), 1'b0, rsp_v_o[t]);
      check_bit($sformatf("%s tile %0d mem_v", phase, t), 1'b0, mem_v_o[t]);
      if (with_ready) begin
        check_bit($sformatf("%s tile %0d req_ready", phase, t), 1'b0, req_ready_o[t]);
      end
    end
  endtask

  // direct-mapped, write-through, no allocate on store
  task automatic model_accept(input int t, input vc_op_e op, input addr_t a, input data_t d);
    tag_t   tg;
    index_t ix;
    {tg, ix} = a;
    exp_op_q[t].push_back(op);
    if (op == OP_STORE) begin
      model_mem[t][a] = d;
      exp_data_q[t].push_back(d);
      exp_mw_q[t].push_back(1'b1);
      exp_ma_q[t].push_back(a);
      exp_md_q[t].push_back(d);
    end else begin
      exp_data_q[t].push_back(model_mem[t][a]);
      if (!line_valid[t][ix] || line_tag[t][ix] != tg) begin
        exp_mw_q[t].push_back(1'b0);
        exp_ma_q[t].push_back(a);
        exp_md_q[t].push_back('0);
        line_valid[t][ix] = 1'b1;
        line_tag[t][ix] = tg;
      end
    end
  endtask

  task automatic drive_requests(input int t);
    logic [31:0] r;
    if (req_v_i[t] && req_ready_o[t]) begin
      model_accept(t, req_op_i[t], req_addr_i[t], req_data_i[t]);
    end
    // fields hold while stalled
    if (!req_v_i[t] || req_ready_o[t]) begin
      r = rand_word();
      if (issued[t] < REQS && r[1:0] != 2'b00) begin
        req_v_i[t] <= 1'b1;
        req_op_i[t] <= (r[4:2] < 3'd3) ? OP_STORE : OP_LOAD;
        req_addr_i[t] <= pick_addr();
        req_data_i[t] <= rand_word();
        issued[t] = issued[t] + 1;
      end else begin
        req_v_i[t] <= 1'b0;
      end
    end
  endtask

  task automatic serve_memory(input int t);
    logic [31:0] r;
    data_t       d;
    mem_rdata_v_i[t] <= 1'b0;
    if (due_q[t].size() > 0 && due_q[t][0] <= cycles) begin
      mem_rdata_v_i[t] <= 1'b1;
      mem_rdata_i[t] <= ret_q[t].pop_front();
      void'(due_q[t].pop_front());
    end
    if (mem_v_o[t] && mem_ready_i[t]) begin
      if (exp_mw_q[t].size() == 0) begin
        $display("tile %0d sent a memory request that none of its requests calls for", t);
        report_fail();
      end else begin
        check_bit($sformatf("tile %0d memory write flag", t), exp_mw_q[t].pop_front(),
                  mem_write_o[t]);
        check_addr($sformatf("tile %0d memory address", t), exp_ma_q[t].pop_front(),
                   mem_addr_o[t]);
        d = exp_md_q[t].pop_front();
        if (mem_write_o[t]) begin
          check_data($sformatf("tile %0d memory write data", t), d, mem_data_o[t]);
          mem_words[t][mem_addr_o[t]] = mem_data_o[t];
          ret_q[t].push_back('0);
        end else begin
          ret_q[t].push_back(mem_words[t][mem_addr_o[t]]);
        end
        r = rand_word();
        due_q[t].push_back(cycles + 1 + int'(r[1:0]));
      end
    end
    r = rand_word();
    mem_ready_i[t] <= (r[1:0] != 2'b00);
  endtask

  task automatic collect_responses(input int t);
    logic [31:0] r;
    if (rsp_v_o[t] && rsp_ready_i[t]) begin
      if (exp_op_q[t].size() == 0) begin
        $display("tile %0d returned a response with no request outstanding", t);
        report_fail();
      end else begin
        check_op($sformatf("tile %0d response op", t), exp_op_q[t].pop_front(), rsp_op_o[t]);
        check_data($sformatf("tile %0d response data", t), exp_data_q[t].pop_front(),
                   rsp_data_o[t]);
        received[t] = received[t] + 1;
      end
    end
    r = rand_word();
    rsp_ready_i[t] <= (r[1:0] != 2'b00);
  endtask

  function automatic logic all_received();
    logic done;
    done = 1'b1;
    for (int t = 0; t < NT; t++) begin
      if (received[t] < REQS) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  task automatic finish_run();
    int left;
    left = 0;
    for (int t = 0; t < NT; t++) begin
      left += exp_op_q[t].size() + exp_mw_q[t].size() + ret_q[t].size();
    end
    if (left == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("%0d expected transfers were never seen by the end of the run", left);
      report_fail();
    end
  endtask

  initial begin
    clk_i = 1'b0;
    rst_i <= 1'b1;
    req_v_i <= '0;
    req_addr_i <= '0;
    req_data_i <= '0;
    rsp_ready_i <= '0;
    mem_ready_i <= '0;
    mem_rdata_v_i <= '0;
    mem_rdata_i <= '0;
    for (int t = 0; t < NT; t++) begin
      req_op_i[t] <= OP_LOAD;
      line_valid[t] = '0;
      for (int a = 0; a < WORDS; a++) begin
        model_mem[t][a] = fill_word(t, a);
        mem_words[t][a] = fill_word(t, a);
      end
    end
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles > LIMIT) begin
      $display("timeout after %0d cycles with responses still missing", LIMIT);
      report_fail();
    end
    if (rst_i) begin
      // registers are known from the second reset edge on
      if (cycles > 1) begin
        check_quiet("during reset", 1'b0);
      end
    end else begin
      if (low_cycles == 0) begin
        check_quiet("first cycle after reset", 1'b1);
      end
      low_cycles = low_cycles + 1;
      for (int t = 0; t < NT; t++) begin
        drive_requests(t);
        serve_memory(t);
        collect_responses(t);
      end
      if (all_received()) begin
        finish_run();
      end
    end
  end

endmodule
